// ==== decodeFrontEnd.f ====
decodePkg.sv
laneResultBus.sv
instrQueue.sv
decodeLane.sv
decodeCollector.sv
decodeTop.sv
decodeTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the decode front end testbench with Verilator, runs it and checks the log

rm -rf obj_dir sim.log \
    && verilator --binary --timing -Wno-fatal --top-module decodeTb \
        -f decodeFrontEnd.f -o decodeSim \
    && ./obj_dir/decodeSim | tee sim.log \
    && grep -q "TEST RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== decodeTb.sv ====
// Decode front end testbench with random APB traffic, a decode model and in-order output checks
`timescale 1ns/100ps

module decodeTb;

    typedef enum logic [1:0] {
        ReadyRandom,
        ReadyLow,
        ReadyHigh
    } readyModeT;

    localparam int NumLanes   = 4;
    localparam int QueueDepth = 8;
    localparam int WaitLimit  = 200;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [7:0]            paddr;
    decodePkg::apbDataT    pwdata;
    decodePkg::apbDataT    prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  outValid;
    logic                  outReady;
    decodePkg::instrClassT outClass;
    logic                  outSpecial;
    logic                  outSetFlags;
    decodePkg::aluFuncT    outAluFunc;
    decodePkg::condT       outBranchCond;
    decodePkg::regIdxT     outDestReg;
    decodePkg::regIdxT     outSrcReg1;
    decodePkg::regIdxT     outSrcReg2;
    decodePkg::immT        outImm;
    logic                  outRegRead;
    logic                  outRegWrite;
    logic                  outHalt;

    logic [31:0]      stimState  = 32'h459c_1e35;
    logic [31:0]      readyState = 32'h459c_1e35;
    readyModeT        readyMode  = ReadyRandom;
    decodePkg::instrT expected [$];
    decodePkg::instrT headWord;
    int               haltCount  = 0;

    decodeTop #(
        .NumLanes   (NumLanes),
        .QueueDepth (QueueDepth)
    ) dut_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==================================================
    // Random source and failure reporting
    // ==================================================

    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            stimState = stepLfsr(stimState);
            value     = {value[30:0], stimState[0]};
        end
        return value;
    endfunction

    // Any address other than the two mapped registers
    function automatic logic [7:0] badAddr();
        logic [7:0] addr;
        addr = 8'(randBits(8));
        if (addr == 8'h00 || addr == 8'h04) begin
            addr = addr + 8'h10;
        end
        return addr;
    endfunction

    task automatic failRun();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compareField(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("[FAIL] time %0t signal %s expected 0x%0h actual 0x%0h",
                     $time, name, expVal, actVal);
            failRun();
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        compareField(name, 32'(expVal), 32'(actVal));
    endtask

    task automatic checkWord(input string name, input decodePkg::apbDataT expVal,
                             input decodePkg::apbDataT actVal);
        compareField(name, expVal, actVal);
    endtask

    // ==================================================
    // Decode model and bundle compare
    // ==================================================

    task automatic checkBundle(input decodePkg::instrT word);
        decodePkg::instrClassT expClass;
        decodePkg::aluFuncT    expAlu;
        decodePkg::condT       expCond;
        decodePkg::regIdxT     expDest;
        decodePkg::regIdxT     expSrc1;
        decodePkg::regIdxT     expSrc2;
        decodePkg::immT        expImm;
        logic                  expRead;
        logic                  expWrite;
        expClass = word[31:30];
        expAlu   = word[27:25];
        expImm   = word[15:0];
        expCond  = '0;
        expDest  = '0;
        expSrc1  = '0;
        expSrc2  = '0;
        expRead  = 1'b0;
        expWrite = 1'b0;
        case (expClass)
            2'b11: begin
                expCond = word[24:21];
                expSrc1 = word[20:17];
                expSrc2 = word[16:13];
                expRead = 1'b1;
            end
            2'b10: begin
                expDest = word[24:21];
                expSrc1 = word[20:17];
            end
            2'b01: begin
                expDest = word[24:21];
                expSrc1 = word[20:17];
                expSrc2 = word[16:13];
            end
            default: begin
                expDest  = word[24:21];
                expSrc1  = word[20:17];
                expRead  = 1'b1;
                expWrite = 1'b1;
            end
        endcase
        compareField("outClass", 32'(expClass), 32'(outClass));
        compareField("outAluFunc", 32'(expAlu), 32'(outAluFunc));
        compareField("outBranchCond", 32'(expCond), 32'(outBranchCond));
        compareField("outDestReg", 32'(expDest), 32'(outDestReg));
        compareField("outSrcReg1", 32'(expSrc1), 32'(outSrcReg1));
        compareField("outSrcReg2", 32'(expSrc2), 32'(outSrcReg2));
        compareField("outImm", 32'(expImm), 32'(outImm));
        checkBit("outSpecial", word[29], outSpecial);
        checkBit("outSetFlags", word[25], outSetFlags);
        checkBit("outRegRead", expRead, outRegRead);
        checkBit("outRegWrite", expWrite, outRegWrite);
        checkBit("outHalt", word[31:25] == 7'b1101000, outHalt);
    endtask

    // ==================================================
    // APB driver, output ready driver and output monitor
    // ==================================================

    // For reads, data is the expected prdata
    task automatic apbAccess(input logic write, input logic [7:0] addr,
                             input decodePkg::apbDataT data, input int stallCycles);
        logic expErr;
        int   waited;
        expErr = write ? (addr != 8'h00) : (addr != 8'h04);
        waited = 0;
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = write ? data : '0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        // Queue full, so the access phase stretches until the output is released
        for (int i = 0; i < stallCycles; i++) begin
            @(negedge clk);
            checkBit("pready", 1'b0, pready);
        end
        if (stallCycles > 0) begin
            readyMode = ReadyHigh;
        end
        @(negedge clk);
        // Reads and error responses never insert a wait state
        if (expErr || !write) begin
            checkBit("pready", 1'b1, pready);
        end
        while (!pready) begin
            waited++;
            if (waited > WaitLimit) begin
                $display("Timeout waiting for pready in the APB access to address 0x%02h", addr);
                failRun();
            end
            @(negedge clk);
        end
        checkBit("pslverr", expErr, pslverr);
        if (!write) begin
            checkWord("prdata", data, prdata);
        end
        if (write && !expErr) begin
            expected.push_back(data);
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        @(posedge clk);
        while (expected.size() != 0) begin
            waited++;
            if (waited > WaitLimit * 4) begin
                $display("Timeout waiting for %0d decoded bundles to come out", expected.size());
                failRun();
            end
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        #2;
        if (readyMode == ReadyRandom) begin
            readyState = stepLfsr(readyState);
            outReady   = readyState[0];
        end else begin
            outReady = (readyMode == ReadyHigh);
        end
    end

    always @(negedge clk) begin
        if (!rst && outValid && outReady) begin
            if (expected.size() == 0) begin
                $display("An output bundle appeared with no accepted write left to match it");
                failRun();
            end else begin
                headWord = expected.pop_front();
                checkBundle(headWord);
                if (outHalt) begin
                    haltCount++;
                end
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        decodePkg::instrT word;
        logic [7:0]       addr;
        logic             write;
        int               accepted;
        $timeformat(-9, 1, " ns", 10);
        rst      = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        outReady = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // Random decode stream with all four classes, halts and stray error accesses
        for (int i = 0; i < 300; i++) begin
            word        = randBits(32);
            word[31:30] = 2'(i % 4);
            if (randBits(3) == 0) begin
                word[31:25] = 7'b1101000;
            end
            apbAccess(1'b1, 8'h00, word, 0);
            if (randBits(4) == 0) begin
                write = (randBits(1) != 0);
                addr  = badAddr();
                apbAccess(write, addr, '0, 0);
            end
        end
        waitDrain();

        // Fill queue, lanes and output register with the output held off
        readyMode = ReadyLow;
        apbAccess(1'b0, 8'h04, 32'd0, 0);
        accepted = 0;
        for (int i = 0; i < QueueDepth + NumLanes + 1; i++) begin
            apbAccess(1'b1, 8'h00, randBits(32), 0);
            accepted++;
        end
        apbAccess(1'b0, 8'h04, 32'(accepted - NumLanes - 1), 0);
        apbAccess(1'b1, 8'h00, randBits(32), 6);
        waitDrain();

        // Error responses mixed into a live stream
        readyMode = ReadyRandom;
        for (int i = 0; i < 12; i++) begin
            apbAccess(1'b1, 8'h00, randBits(32), 0);
            write = (randBits(1) != 0);
            addr  = badAddr();
            apbAccess(write, addr, '0, 0);
        end
        apbAccess(1'b1, 8'h04, 32'h1234_5678, 0);
        apbAccess(1'b0, 8'h00, '0, 0);
        waitDrain();
        @(negedge clk);
        checkBit("outValid", 1'b0, outValid);

        if (haltCount == 0) begin
            $display("No halt bundle came out, so the halt decode was never exercised");
            failRun();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== decodeTop.sv ====
// Decode front end top level joining the APB queue, the decode lanes and the collector
`timescale 1ns/100ps

module decodeTop #(
    parameter int NumLanes   = 4,
    parameter int QueueDepth = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  decodePkg::apbDataT    pwdata,
    output decodePkg::apbDataT    prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Decoded output stream
    output logic                  outValid,
    input  logic                  outReady,
    output decodePkg::instrClassT outClass,
    output logic                  outSpecial,
    output logic                  outSetFlags,
    output decodePkg::aluFuncT    outAluFunc,
    output decodePkg::condT       outBranchCond,
    output decodePkg::regIdxT     outDestReg,
    output decodePkg::regIdxT     outSrcReg1,
    output decodePkg::regIdxT     outSrcReg2,
    output decodePkg::immT        outImm,
    output logic                  outRegRead,
    output logic                  outRegWrite,
    output logic                  outHalt
);

    decodePkg::instrT    laneInstr [NumLanes];
    logic [NumLanes-1:0] laneValid;
    logic [NumLanes-1:0] laneReady;

    laneResultBus resultBus [NumLanes] ();

    instrQueue #(
        .NumLanes   (NumLanes),
        .QueueDepth (QueueDepth)
    ) queueInst (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .laneInstr (laneInstr),
        .laneValid (laneValid),
        .laneReady (laneReady)
    );

    for (genvar i = 0; i < NumLanes; i++) begin : laneGen
        decodeLane laneInst (
            .clk        (clk),
            .rst        (rst),
            .instr      (laneInstr[i]),
            .instrValid (laneValid[i]),
            .instrReady (laneReady[i]),
            .result     (resultBus[i])
        );
    end

    decodeCollector #(
        .NumLanes (NumLanes)
    ) collectorInst (
        .clk           (clk),
        .rst           (rst),
        .lanes         (resultBus),
        .outValid      (outValid),
        .outReady      (outReady),
        .outClass      (outClass),
        .outSpecial    (outSpecial),
        .outSetFlags   (outSetFlags),
        .outAluFunc    (outAluFunc),
        .outBranchCond (outBranchCond),
        .outDestReg    (outDestReg),
        .outSrcReg1    (outSrcReg1),
        .outSrcReg2    (outSrcReg2),
        .outImm        (outImm),
        .outRegRead    (outRegRead),
        .outRegWrite   (outRegWrite),
        .outHalt       (outHalt)
    );

endmodule

// ==== decodeCollector.sv ====
// Collector that drains the decode lanes in program order onto a registered output port
`timescale 1ns/100ps

module decodeCollector #(
    parameter int NumLanes = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    laneResultBus.collector        lanes [NumLanes],
    output logic                   outValid,
    input  logic                   outReady,
    output decodePkg::instrClassT  outClass,
    output logic                   outSpecial,
    output logic                   outSetFlags,
    output decodePkg::aluFuncT     outAluFunc,
    output decodePkg::condT        outBranchCond,
    output decodePkg::regIdxT      outDestReg,
    output decodePkg::regIdxT      outSrcReg1,
    output decodePkg::regIdxT      outSrcReg2,
    output decodePkg::immT         outImm,
    output logic                   outRegRead,
    output logic                   outRegWrite,
    output logic                   outHalt
);

    localparam int PtrW    = (NumLanes > 1) ? $clog2(NumLanes) : 1;
    localparam int BundleW = $bits(decodePkg::instrClassT) + $bits(decodePkg::aluFuncT)
        + $bits(decodePkg::condT) + 3 * $bits(decodePkg::regIdxT)
        + $bits(decodePkg::immT) + 5;

    logic [BundleW-1:0]  laneBundle [NumLanes];
    logic [NumLanes-1:0] laneValid;
    logic [BundleW-1:0]  outBundle;
    logic [PtrW-1:0]     drainPtr;
    logic                takeOk;
    logic                take;

    // Output register is free, or its content leaves this cycle
    assign takeOk = !outValid || outReady;
    assign take   = takeOk && laneValid[drainPtr];

    // Flatten each lane bundle so the drain pointer can select it
    for (genvar i = 0; i < NumLanes; i++) begin : laneTap
        assign laneValid[i]  = lanes[i].valid;
        assign laneBundle[i] = {lanes[i].instrClass, lanes[i].special, lanes[i].setFlags,
                                lanes[i].aluFunc, lanes[i].branchCond, lanes[i].destReg,
                                lanes[i].srcReg1, lanes[i].srcReg2, lanes[i].imm,
                                lanes[i].regRead, lanes[i].regWrite, lanes[i].halt};
        assign lanes[i].ready = takeOk && (drainPtr == PtrW'(i));
    end

    // ==================================================
    // Drain pointer and output register
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            drainPtr <= '0;
        end else if (take) begin
            outValid <= 1'b1;
            drainPtr <= (drainPtr == PtrW'(NumLanes - 1)) ? '0 : drainPtr + 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            outBundle <= laneBundle[drainPtr];
        end
    end

    assign {outClass, outSpecial, outSetFlags, outAluFunc, outBranchCond, outDestReg,
            outSrcReg1, outSrcReg2, outImm, outRegRead, outRegWrite, outHalt} = outBundle;

endmodule

// ==== decodeLane.sv ====
// Decode lane that holds one instruction word and presents its decoded bundle until taken
`timescale 1ns/100ps

module decodeLane (
    input  logic             clk,
    input  logic             rst,
    input  decodePkg::instrT instr,
    input  logic             instrValid,
    output logic             instrReady,
    laneResultBus.lane       result
);

    typedef enum logic {
        LaneIdle,
        LaneFull
    } laneStateT;

    laneStateT             state;
    decodePkg::instrT      heldInstr;
    decodePkg::instrClassT instrClass;

    // ==================================================
    // Hold register and handshake
    // ==================================================

    assign instrReady   = (state == LaneIdle);
    assign result.valid = (state == LaneFull);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LaneIdle;
        end else begin
            case (state)
                LaneIdle: begin
                    if (instrValid) begin
                        state <= LaneFull;
                    end
                end
                LaneFull: begin
                    // Free again once the collector has taken the bundle
                    if (result.ready) begin
                        state <= LaneIdle;
                    end
                end
                default: begin
                    state <= LaneIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid && instrReady) begin
            heldInstr <= instr;
        end
    end

    // ==================================================
    // Field decode
    // ==================================================

    assign instrClass = heldInstr[31:30];

    always_comb begin
        // Fields shared by every class
        result.instrClass = instrClass;
        result.special    = heldInstr[29];
        result.setFlags   = heldInstr[25];
        result.aluFunc    = heldInstr[27:25];
        result.imm        = heldInstr[15:0];
        result.halt       = (heldInstr[31:25] == decodePkg::HaltOpcode);

        // Class specific fields stay zero unless the class uses them
        result.branchCond = '0;
        result.destReg    = '0;
        result.srcReg1    = '0;
        result.srcReg2    = '0;
        result.regRead    = 1'b0;
        result.regWrite   = 1'b0;

        case (instrClass)
            decodePkg::ClassBranch: begin
                result.branchCond = heldInstr[24:21];
                result.srcReg1    = heldInstr[20:17];
                result.srcReg2    = heldInstr[16:13];
                result.regRead    = 1'b1;
            end
            decodePkg::ClassLoadStore: begin
                result.destReg = heldInstr[24:21];
                result.srcReg1 = heldInstr[20:17];
            end
            decodePkg::ClassRegAlu: begin
                result.destReg = heldInstr[24:21];
                result.srcReg1 = heldInstr[20:17];
                result.srcReg2 = heldInstr[16:13];
            end
            decodePkg::ClassImmAlu: begin
                result.destReg  = heldInstr[24:21];
                result.srcReg1  = heldInstr[20:17];
                result.regRead  = 1'b1;
                result.regWrite = 1'b1;
            end
        endcase
    end

endmodule

// ==== instrQueue.sv ====
// Instruction queue with an APB write port that dispatches words round robin to the lanes
`timescale 1ns/100ps

module instrQueue #(
    parameter int NumLanes   = 4,
    parameter int QueueDepth = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [7:0]          paddr,
    input  decodePkg::apbDataT  pwdata,
    output decodePkg::apbDataT  prdata,
    output logic                pready,
    output logic                pslverr,
    output decodePkg::instrT    laneInstr [NumLanes],
    output logic [NumLanes-1:0] laneValid,
    input  logic [NumLanes-1:0] laneReady
);

    localparam int AddrW    = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int LevelW   = $clog2(QueueDepth + 1);
    localparam int LanePtrW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

    decodePkg::instrT    mem [QueueDepth];
    logic [AddrW-1:0]    wrPtr;
    logic [AddrW-1:0]    rdPtr;
    logic [LevelW-1:0]   level;
    logic [LanePtrW-1:0] dispPtr;

    logic access;
    logic isInstr;
    logic isLevel;
    logic full;
    logic empty;
    logic push;
    logic pop;

    // ==================================================
    // APB decode
    // ==================================================

    assign access  = psel && penable;
    assign isInstr = (paddr == decodePkg::AddrInstr);
    assign isLevel = (paddr == decodePkg::AddrLevel);
    assign full    = (level == LevelW'(QueueDepth));
    assign empty   = (level == '0);

    // Instruction writes stretch the access phase while the queue is full
    assign pready  = !(access && pwrite && isInstr && full);
    assign push    = access && pwrite && isInstr && !full;

    // Only instruction writes and level reads are legal
    assign pslverr = access && !((pwrite && isInstr) || (!pwrite && isLevel));

    always_comb begin
        prdata = '0;
        if (access && !pwrite && isLevel) begin
            prdata[LevelW-1:0] = level;
        end
    end

    // ==================================================
    // Dispatch to lanes
    // ==================================================

    // Head goes out on every lane, but only the pointed lane sees valid
    assign pop = !empty && laneReady[dispPtr];

    always_comb begin
        for (int i = 0; i < NumLanes; i++) begin
            laneInstr[i] = mem[rdPtr];
            laneValid[i] = !empty && (dispPtr == LanePtrW'(i));
        end
    end

    // ==================================================
    // FIFO storage and pointers
    // ==================================================

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            level   <= '0;
            dispPtr <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == AddrW'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr   <= (rdPtr == AddrW'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
                dispPtr <= (dispPtr == LanePtrW'(NumLanes - 1)) ? '0 : dispPtr + 1'b1;
            end
            // Level moves only when exactly one side is active
            if (push && !pop) begin
                level <= level + 1'b1;
            end else if (pop && !push) begin
                level <= level - 1'b1;
            end
        end
    end

endmodule

// ==== laneResultBus.sv ====
// Decoded bundle of one decode lane toward the collector, with valid/ready handshake
`timescale 1ns/100ps

interface laneResultBus;

    // Handshake
    logic                  valid;
    logic                  ready;

    // Decoded fields, stable while valid is high
    decodePkg::instrClassT instrClass;
    logic                  special;
    logic                  setFlags;
    decodePkg::aluFuncT    aluFunc;
    decodePkg::condT       branchCond;
    decodePkg::regIdxT     destReg;
    decodePkg::regIdxT     srcReg1;
    decodePkg::regIdxT     srcReg2;
    decodePkg::immT        imm;
    logic                  regRead;
    logic                  regWrite;
    logic                  halt;

    modport lane (
        output valid, instrClass, special, setFlags, aluFunc, branchCond,
        output destReg, srcReg1, srcReg2, imm, regRead, regWrite, halt,
        input  ready
    );

    modport collector (
        input  valid, instrClass, special, setFlags, aluFunc, branchCond,
        input  destReg, srcReg1, srcReg2, imm, regRead, regWrite, halt,
        output ready
    );

endinterface

// ==== decodePkg.sv ====
// Decode front end package with instruction field types, class codes and APB register map
package decodePkg;

    // ==================================================
    // Instruction word and field types
    // ==================================================

    // Full instruction word as written by the host
    typedef logic [31:0] instrT;

    // Bits 31:30
    typedef logic [1:0] instrClassT;

    // Bits 27:25
    typedef logic [2:0] aluFuncT;

    // Bits 24:21 when the class is branch
    typedef logic [3:0] condT;

    // Destination at 24:21, sources at 20:17 and 16:13
    typedef logic [3:0] regIdxT;

    // Bits 15:0, overlaps the second source on purpose
    typedef logic [15:0] immT;

    // ==================================================
    // Class codes and special opcodes
    // ==================================================

    localparam instrClassT ClassBranch    = 2'b11;
    localparam instrClassT ClassLoadStore = 2'b10;
    localparam instrClassT ClassRegAlu    = 2'b01;
    localparam instrClassT ClassImmAlu    = 2'b00;

    // Halt matches on bits 31:25 as a whole, so it is a branch with a fixed upper field
    localparam logic [6:0] HaltOpcode = 7'b1101000;

    // ==================================================
    // APB register map
    // ==================================================

    typedef logic [31:0] apbDataT;

    // Write only, pushes one instruction word
    localparam logic [7:0] AddrInstr = 8'h00;

    // Read only, current queue fill level
    localparam logic [7:0] AddrLevel = 8'h04;

endpackage
